// File: run_sim.sh
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_viterbi -f viterbi_decoder.f -o sim_viterbi

./obj_dir/sim_viterbi > sim.log 2>&1 || true
cat sim.log

if grep -q "Regression passed" sim.log; then
    exit 0
else
    exit 1
fi

// File: tests/tb_clock.sv
`timescale 1ns/1ns

module tb_clock (
    output logic clk
);

    // 20 ns period
    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

endmodule

// File: tests/tb_viterbi.sv
`timescale 1ns/1ns

module tb_viterbi import viterbi_pkg::*; ();

    localparam int TB_DEPTH   = 16;
    localparam int CREDIT_MAX = 4;
    localparam int WAIT_MAX   = 200;

    logic    clk;
    logic    rst_n;
    symbol_t in_symbol;
    logic    in_valid;
    logic    in_ready;
    logic    out_bit;
    logic    out_valid;
    logic    out_credit;

    // Pairs of words per symbol, received symbol then original bit
    logic [3:0] stim [0:255];
    int         num_sym;
    int         total_out;
    int         out_count;
    int         granted;

    tb_clock u_clk (.clk(clk));

    viterbi_decoder #(
        .TB_DEPTH   (TB_DEPTH),
        .CREDIT_MAX (CREDIT_MAX)
    ) UUT (
        .clk        (clk),
        .rst_n      (rst_n),
        .in_symbol  (in_symbol),
        .in_valid   (in_valid),
        .in_ready   (in_ready),
        .out_bit    (out_bit),
        .out_valid  (out_valid),
        .out_credit (out_credit)
    );

    task automatic fail_run(input string msg);
        $display("%s", msg);
        $display("Regression failed");
        $fatal(1);
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            fail_run($sformatf("ERROR t=%0t %s got %b expected %b", $time, name, got, exp));
        end
    endtask

    task automatic check_count(input string name, input int got, input int exp);
        if (got != exp) begin
            fail_run($sformatf("ERROR t=%0t %s got %0d expected %0d", $time, name, got, exp));
        end
    endtask

    ////////////////////////////////////////////////////////////
    // Output monitor, sampled mid cycle
    ////////////////////////////////////////////////////////////

    always @(negedge clk) begin
        if (rst_n && out_valid) begin
            // Output k decodes the bit of symbol k
            check_bit("out_bit", out_bit, stim[2*out_count+1][0]);
            out_count++;
            if (out_count > granted) begin
                fail_run("more out_valid pulses than credits granted");
            end
        end
    end

    task automatic send_symbols();
        int gap;
        int waited;
        for (int i = 0; i < num_sym; i++) begin
            gap = $urandom % 3;
            repeat (gap) begin
                @(posedge clk);
                #2;
            end
            in_valid  = 1'b1;
            in_symbol = stim[2*i][1:0];
            waited    = 0;
            @(negedge clk);
            while (!in_ready) begin
                waited++;
                if (waited > WAIT_MAX) begin
                    fail_run("timeout waiting for in_ready");
                end
                @(negedge clk);
            end
            @(posedge clk);
            #2;
            in_valid = 1'b0;
        end
    endtask

    task automatic return_credits();
        int low_run;
        int waited;
        int gap;
        int idle;
        int last;
        low_run = 0;
        waited  = 0;
        // A bit is pending once in_ready stays low longer than a trace
        while (low_run < 20) begin
            @(negedge clk);
            waited++;
            if (waited > WAIT_MAX) begin
                fail_run("timeout waiting for a pending output bit");
            end
            low_run = in_ready ? 0 : low_run + 1;
        end
        // Hold back credits, nothing may leave
        repeat (40) begin
            @(negedge clk);
            check_bit("out_valid", out_valid, 1'b0);
            check_bit("in_ready", in_ready, 1'b0);
        end
        idle = 0;
        last = out_count;
        while (out_count < total_out) begin
            gap = $urandom % 6;
            repeat (gap + 1) begin
                @(posedge clk);
                #2;
                out_credit = 1'b0;
                idle = (out_count == last) ? idle + 1 : 0;
                last = out_count;
                if (idle > WAIT_MAX) begin
                    fail_run("timeout waiting for a decoded bit");
                end
            end
            if (granted - out_count < CREDIT_MAX) begin
                out_credit = 1'b1;
                granted++;
            end
        end
        @(posedge clk);
        #2;
        out_credit = 1'b0;
    endtask

    initial begin
        void'($urandom(32'h9c0a));
        rst_n      = 1'b0;
        in_valid   = 1'b0;
        in_symbol  = '0;
        out_credit = 1'b0;
        out_count  = 0;
        granted    = 0;
        total_out  = 0;
        for (int i = 0; i < 256; i++) begin
            stim[i] = 4'hf;
        end
        $readmemh("tests/viterbi_stim.txt", stim);
        num_sym = 0;
        while (num_sym < 128 && stim[2*num_sym] != 4'hf) begin
            num_sym++;
        end
        if (num_sym <= TB_DEPTH - 1) begin
            fail_run("stimulus file holds too few symbols");
        end
        total_out = num_sym - (TB_DEPTH - 1);

        repeat (2) @(posedge clk);
        #2;
        rst_n = 1'b1;
        @(negedge clk);
        check_bit("in_ready", in_ready, 1'b1);
        check_bit("out_valid", out_valid, 1'b0);
        @(posedge clk);
        #2;

        fork
            send_symbols();
            return_credits();
        join

        // Leftover credits give any stray bit a chance to show in the count
        repeat (20) begin
            @(negedge clk);
        end
        check_count("output bits", out_count, total_out);
        $display("Regression passed");
        $finish;
    end

endmodule

// File: tests/viterbi_stim.txt
// Columns: received symbol (bit 1 is G0 parity), original input bit
// Terminated by a line of f f
// Error-free section
3 1
3 0
1 1
3 1
1 0
1 0
0 1
3 0
1 1
3 1
2 1
2 0
1 0
// Corrupted section, single-bit errors at symbols 13 and 22
1 1
3 0
1 1
0 0
2 0
0 1
0 1
1 0
2 1
1 1
2 1
2 0
2 1
0 0
2 0
3 0
// Flush zeros
0 0
0 0
0 0
0 0
0 0
0 0
0 0
0 0
0 0
0 0
0 0
0 0
0 0
0 0
f f

// File: verilog/acs_unit.sv
`timescale 1ns/1ns

module acs_unit import viterbi_pkg::*; (
    input  logic    clk,
    input  logic    rst_n,
    input  logic    accept,
    input  symbol_t in_symbol,
    output state_t  best_state,
    survivor_if.writer surv
);

    metric_t   pm      [NUM_STATES];
    metric_t   acs_sum [NUM_STATES];
    metric_t   pm_nxt  [NUM_STATES];
    decision_t dec;
    logic      all_msb;

    // Hamming distance between the received symbol and one branch label
    function automatic logic [1:0] branch_metric(symbol_t rx, state_t nxt, logic odd);
        logic [K-1:0] shreg;
        symbol_t      expected;
        symbol_t      diff;
        shreg    = {nxt, odd};
        expected = {^(shreg & G0), ^(shreg & G1)};
        diff     = rx ^ expected;
        return {1'b0, diff[1]} + {1'b0, diff[0]};
    endfunction

    ////////////////////////////////////////////////////////////
    // Add-compare-select
    ////////////////////////////////////////////////////////////

    // Predecessors of state n are {n[1:0], 0} and {n[1:0], 1}
    always_comb begin
        metric_t cand_even;
        metric_t cand_odd;
        state_t  ns;
        for (int n = 0; n < NUM_STATES; n++) begin
            ns        = state_t'(n);
            cand_even = pm[{ns[K-3:0], 1'b0}] + metric_t'(branch_metric(in_symbol, ns, 1'b0));
            cand_odd  = pm[{ns[K-3:0], 1'b1}] + metric_t'(branch_metric(in_symbol, ns, 1'b1));
            // Even predecessor wins a tie
            dec[n]     = (cand_odd < cand_even);
            acs_sum[n] = dec[n] ? cand_odd : cand_even;
        end
    end

    // Normalize by dropping the MSB once every metric has it set
    always_comb begin
        all_msb = 1'b1;
        for (int n = 0; n < NUM_STATES; n++) begin
            all_msb = all_msb & acs_sum[n][METRIC_W-1];
        end
        for (int n = 0; n < NUM_STATES; n++) begin
            pm_nxt[n] = acs_sum[n];
            if (all_msb) begin
                pm_nxt[n][METRIC_W-1] = 1'b0;
            end
        end
    end

    // Best state from the metrics about to be stored, so it is valid at the accept edge
    always_comb begin
        metric_t best_metric;
        best_metric = pm_nxt[0];
        best_state  = '0;
        for (int s = 1; s < NUM_STATES; s++) begin
            if (pm_nxt[s] < best_metric) begin
                best_metric = pm_nxt[s];
                best_state  = state_t'(s);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int s = 0; s < NUM_STATES; s++) begin
                pm[s] <= (s == 0) ? '0 : INIT_METRIC;
            end
        end else if (accept) begin
            for (int s = 0; s < NUM_STATES; s++) begin
                pm[s] <= pm_nxt[s];
            end
        end
    end

    // Decision row goes to the survivor memory on the same edge
    assign surv.wr_en  = accept;
    assign surv.wr_dec = dec;

endmodule

// File: verilog/decode_ctrl.sv
`timescale 1ns/1ns

module decode_ctrl import viterbi_pkg::*; #(
    parameter int CREDIT_MAX = 4
) (
    input  logic clk,
    input  logic rst_n,
    input  logic in_valid,
    output logic in_ready,
    output logic accept,
    input  logic window_full,
    input  logic trace_done,
    output logic trace_start,
    input  logic out_credit,
    output logic out_valid
);

    localparam int CREDIT_W = $clog2(CREDIT_MAX + 1);

    ctrl_state_e         state;
    ctrl_state_e         state_nxt;
    logic [CREDIT_W-1:0] credit_cnt;
    logic                has_credit;

    // Input side handshake
    assign in_ready    = (state == ST_ACCEPT);
    assign accept      = in_valid && in_ready;
    assign trace_start = accept && window_full;

    // Output side, one bit per held credit
    assign has_credit = (credit_cnt != '0);
    assign out_valid  = (state == ST_EMIT) && has_credit;

    always_comb begin
        state_nxt = state;
        case (state)
            ST_ACCEPT: begin
                if (trace_start) begin
                    state_nxt = ST_TRACE;
                end
            end
            ST_TRACE: begin
                if (trace_done) begin
                    state_nxt = ST_EMIT;
                end
            end
            ST_EMIT: begin
                if (out_valid) begin
                    state_nxt = ST_ACCEPT;
                end
            end
            default: state_nxt = ST_ACCEPT;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state <= ST_ACCEPT;
        end else begin
            state <= state_nxt;
        end
    end

    ////////////////////////////////////////////////////////////
    // Credit counter, saturates at CREDIT_MAX
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            credit_cnt <= '0;
        end else begin
            case ({out_credit, out_valid})
                2'b10: begin
                    if (credit_cnt != CREDIT_W'(CREDIT_MAX)) begin
                        credit_cnt <= credit_cnt + 1'b1;
                    end
                end
                2'b01: credit_cnt <= credit_cnt - 1'b1;
                default: credit_cnt <= credit_cnt;
            endcase
        end
    end

    // A bit sent without a credit in hand would wrap the count below zero
    a_credit_range: assert property (@(posedge clk) disable iff (!rst_n)
        credit_cnt <= CREDIT_W'(CREDIT_MAX));

    a_accept_state: assert property (@(posedge clk) disable iff (!rst_n)
        accept |-> state == ST_ACCEPT);

endmodule

// File: verilog/survivor_if.sv
`timescale 1ns/1ns

interface survivor_if import viterbi_pkg::*; #(
    parameter int TB_DEPTH = 16
) ();

    localparam int PTR_W = $clog2(TB_DEPTH);

    // Write port, one decision row per accepted symbol
    logic              wr_en;
    decision_t         wr_dec;
    logic [PTR_W-1:0]  wr_ptr;

    // Traceback read port
    logic [PTR_W-1:0]  rd_ptr;
    decision_t         rd_dec;

    modport writer  (output wr_en, output wr_dec);
    modport pointer (output wr_ptr, output rd_ptr);
    modport reader  (input rd_dec);
    modport mem     (input wr_en, input wr_dec, input wr_ptr, input rd_ptr, output rd_dec);

endinterface

// File: verilog/survivor_mem.sv
`timescale 1ns/1ns

module survivor_mem import viterbi_pkg::*; #(
    parameter int TB_DEPTH = 16
) (
    input logic clk,
    survivor_if.mem surv
);

    // One decision row per symbol, written in a circle
    decision_t rows [TB_DEPTH];

    always_ff @(posedge clk) begin
        if (surv.wr_en) begin
            rows[surv.wr_ptr] <= surv.wr_dec;
        end
    end

    // Combinational read, the row written last edge is visible now
    assign surv.rd_dec = rows[surv.rd_ptr];

endmodule

// File: verilog/traceback_unit.sv
`timescale 1ns/1ns

module traceback_unit import viterbi_pkg::*; #(
    parameter int TB_DEPTH = 16
) (
    input  logic   clk,
    input  logic   rst_n,
    input  logic   trace_start,
    input  state_t best_state,
    output logic   out_bit,
    survivor_if.reader surv
);

    localparam int STEP_W = $clog2(TB_DEPTH);

    state_t            tb_state;
    state_t            pred_state;
    logic [STEP_W-1:0] steps_left;

    // Shift the older bits up, the stored decision fills the LSB
    assign pred_state = {tb_state[K-3:0], surv.rd_dec[tb_state]};

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            tb_state   <= '0;
            steps_left <= '0;
        end else if (trace_start) begin
            tb_state   <= best_state;
            steps_left <= STEP_W'(TB_DEPTH - 1);
        end else if (steps_left != '0) begin
            tb_state   <= pred_state;
            steps_left <= steps_left - 1'b1;
        end
    end

    // Newest bit of the oldest state reached, held until the next trace
    assign out_bit = tb_state[K-2];

    // Controller never restarts a walk that is still running
    a_no_overlap: assert property (@(posedge clk) disable iff (!rst_n)
        trace_start |-> steps_left == '0);

endmodule

// File: verilog/viterbi_decoder.sv
`timescale 1ns/1ns

module viterbi_decoder import viterbi_pkg::*; #(
    parameter int TB_DEPTH   = 16,
    parameter int CREDIT_MAX = 4
) (
    input  logic    clk,
    input  logic    rst_n,
    input  symbol_t in_symbol,
    input  logic    in_valid,
    output logic    in_ready,
    output logic    out_bit,
    output logic    out_valid,
    input  logic    out_credit
);

    logic   accept;
    logic   window_full;
    logic   trace_start;
    logic   trace_done;
    state_t best_state;

    survivor_if #(.TB_DEPTH(TB_DEPTH)) surv_bus ();

    decode_ctrl #(
        .CREDIT_MAX (CREDIT_MAX)
    ) u_ctrl (
        .clk         (clk),
        .rst_n       (rst_n),
        .in_valid    (in_valid),
        .in_ready    (in_ready),
        .accept      (accept),
        .window_full (window_full),
        .trace_done  (trace_done),
        .trace_start (trace_start),
        .out_credit  (out_credit),
        .out_valid   (out_valid)
    );

    window_counter #(
        .TB_DEPTH (TB_DEPTH)
    ) u_window (
        .clk         (clk),
        .rst_n       (rst_n),
        .accept      (accept),
        .trace_start (trace_start),
        .window_full (window_full),
        .trace_done  (trace_done),
        .surv        (surv_bus.pointer)
    );

    acs_unit u_acs (
        .clk        (clk),
        .rst_n      (rst_n),
        .accept     (accept),
        .in_symbol  (in_symbol),
        .best_state (best_state),
        .surv       (surv_bus.writer)
    );

    survivor_mem #(
        .TB_DEPTH (TB_DEPTH)
    ) u_mem (
        .clk  (clk),
        .surv (surv_bus.mem)
    );

    traceback_unit #(
        .TB_DEPTH (TB_DEPTH)
    ) u_traceback (
        .clk         (clk),
        .rst_n       (rst_n),
        .trace_start (trace_start),
        .best_state  (best_state),
        .out_bit     (out_bit),
        .surv        (surv_bus.reader)
    );

endmodule

// File: verilog/viterbi_pkg.sv
package viterbi_pkg;

    ////////////////////////////////////////////////////////////
    // Code definition
    ////////////////////////////////////////////////////////////

    // Constraint length and trellis size
    localparam int K          = 4;
    localparam int NUM_STATES = 1 << (K - 1);

    // Generator taps, MSB is the newest input bit
    localparam logic [K-1:0] G0 = 4'o17;
    localparam logic [K-1:0] G1 = 4'o15;

    // Path metric width
    localparam int METRIC_W = 8;

    ////////////////////////////////////////////////////////////
    // Types
    ////////////////////////////////////////////////////////////

    // Received symbol, bit 1 is the G0 parity
    typedef logic [1:0] symbol_t;

    // Last K-1 input bits, newest in the MSB
    typedef logic [K-2:0] state_t;

    typedef logic [METRIC_W-1:0] metric_t;

    // Bit s set when state s came from its odd predecessor
    typedef logic [NUM_STATES-1:0] decision_t;

    // Start value for every state other than 0
    localparam metric_t INIT_METRIC = 8'd64;

    typedef enum logic [1:0] {
        ST_ACCEPT,
        ST_TRACE,
        ST_EMIT
    } ctrl_state_e;

endpackage

// File: verilog/window_counter.sv
`timescale 1ns/1ns

module window_counter #(
    parameter int TB_DEPTH = 16
) (
    input  logic clk,
    input  logic rst_n,
    input  logic accept,
    input  logic trace_start,
    output logic window_full,
    output logic trace_done,
    survivor_if.pointer surv
);

    localparam int PTR_W  = $clog2(TB_DEPTH);
    localparam int FILL_W = $clog2(TB_DEPTH + 1);

    logic [FILL_W-1:0] fill_cnt;
    logic [PTR_W-1:0]  step_cnt;

    // Window is full once this accept lands
    assign window_full = (fill_cnt >= FILL_W'(TB_DEPTH - 1));
    assign trace_done  = (step_cnt == PTR_W'(1));

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            fill_cnt    <= '0;
            step_cnt    <= '0;
            surv.wr_ptr <= '0;
            surv.rd_ptr <= '0;
        end else begin
            if (accept) begin
                surv.wr_ptr <= (surv.wr_ptr == PTR_W'(TB_DEPTH - 1)) ? '0 : surv.wr_ptr + 1'b1;
                if (fill_cnt != FILL_W'(TB_DEPTH)) begin
                    fill_cnt <= fill_cnt + 1'b1;
                end
            end
            // Row being written now is the newest one to trace from
            if (trace_start) begin
                surv.rd_ptr <= surv.wr_ptr;
                step_cnt    <= PTR_W'(TB_DEPTH - 1);
            end else if (step_cnt != '0) begin
                surv.rd_ptr <= (surv.rd_ptr == '0) ? PTR_W'(TB_DEPTH - 1) : surv.rd_ptr - 1'b1;
                step_cnt    <= step_cnt - 1'b1;
            end
        end
    end

    a_fill_bound: assert property (@(posedge clk) disable iff (!rst_n)
        fill_cnt <= FILL_W'(TB_DEPTH));

endmodule

// File: viterbi_decoder.f
verilog/viterbi_pkg.sv
verilog/survivor_if.sv
verilog/decode_ctrl.sv
verilog/window_counter.sv
verilog/acs_unit.sv
verilog/survivor_mem.sv
verilog/traceback_unit.sv
verilog/viterbi_decoder.sv
tests/tb_clock.sv
tests/tb_viterbi.sv
